//--- project.f
hw/coreDefs.sv
hw/pipeBus.sv
hw/regFile.sv
hw/fetchStage.sv
hw/decodeStage.sv
hw/executeStage.sv
hw/memoryStage.sv
hw/hazardUnit.sv
hw/processor.sv
tests/processor_props.sv
tests/processorTb.sv

//--- run.sh
#!/bin/sh
# Build the processor testbench with Verilator, run it, and judge the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module processorTb -Mdir obj_dir -o simv -f project.f

./obj_dir/simv | tee sim.log

if grep -q "Simulation completed successfully" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi

//--- tests/processorTb.sv
`default_nettype none

module processorTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int ProgLen = 34;
    localparam int StoreCount = 10;
    localparam int TimeoutCycles = (ProgLen + 10 * StoreCount) * 8;
    localparam logic [31:0] Marker = 32'h0000_07AD;

    // Hand-assembled program indexed by pc / 4
    localparam logic [31:0] Program [ProgLen] = '{
        32'h00C0_0093,  // 00 addi x1, x0, 12
        32'h0050_0113,  // 04 addi x2, x0, 5
        32'h0020_81B3,  // 08 add  x3, x1, x2
        32'h4021_8233,  // 0c sub  x4, x3, x2
        32'h0021_F2B3,  // 10 and  x5, x3, x2
        32'h0042_E333,  // 14 or   x6, x5, x4
        32'h0013_43B3,  // 18 xor  x7, x6, x1
        32'hFFD0_0493,  // 1c addi x9, x0, -3
        32'h0074_A533,  // 20 slt  x10, x9, x7
        32'h1234_55B7,  // 24 lui  x11, 0x12345
        32'h6785_8593,  // 28 addi x11, x11, 0x678
        32'h00B0_2C23,  // 2c sw   x11, 24(x0)
        32'h0030_2023,  // 30 sw   x3, 0(x0)
        32'h0040_2223,  // 34 sw   x4, 4(x0)
        32'h0050_2423,  // 38 sw   x5, 8(x0)
        32'h0060_2623,  // 3c sw   x6, 12(x0)
        32'h0070_2823,  // 40 sw   x7, 16(x0)
        32'h00A0_2A23,  // 44 sw   x10, 20(x0)
        32'h0000_2603,  // 48 lw   x12, 0(x0)
        32'h0646_0693,  // 4c addi x13, x12, 100
        32'h00D0_2E23,  // 50 sw   x13, 28(x0)
        32'h7AD0_0713,  // 54 addi x14, x0, 0x7ad
        32'h0040_8663,  // 58 beq  x1, x4, +12
        32'h02E0_2023,  // 5c sw   x14, 32(x0)
        32'h02E0_2223,  // 60 sw   x14, 36(x0)
        32'h0040_9463,  // 64 bne  x1, x4, +8
        32'h0220_2423,  // 68 sw   x2, 40(x0)
        32'h00C0_07EF,  // 6c jal  x15, +12
        32'h02E0_2623,  // 70 sw   x14, 44(x0)
        32'h02E0_2823,  // 74 sw   x14, 48(x0)
        32'h02F0_2A23,  // 78 sw   x15, 52(x0)
        32'h0000_0073,  // 7c ecall
        32'h02E0_2C23,  // 80 sw   x14, 56(x0)
        32'h02E0_2E23   // 84 sw   x14, 60(x0)
    };

    // Stores in program order
    localparam logic [31:0] StoreAddr [StoreCount] = '{
        32'd24, 32'd0, 32'd4, 32'd8, 32'd12, 32'd16, 32'd20, 32'd28, 32'd40, 32'd52
    };
    localparam logic [31:0] StoreData [StoreCount] = '{
        32'h1234_5678, 32'd17, 32'd12, 32'd1, 32'd13, 32'd1, 32'd1, 32'd117, 32'd5,
        32'h0000_0070
    };
    string storeName [StoreCount] = '{
        "lui_addi", "add", "sub", "and", "or", "xor", "slt", "load_use", "bne_fall",
        "jal_link"
    };

    logic clk = 1'b0;
    logic rst, startProcess, endProcess;
    logic [31:0] instructionIF, pcIF, aluOutMem, rs2DataMem;
    logic [31:0] dMOutMem = '0;
    logic dMReadyMem = 1'b0;
    logic memReadMem, memWriteMem;

    logic [31:0] dataMem [64];
    logic [31:0] heldAddr, heldData, rnd;
    logic [1:0] waitLeft;
    logic busy;
    logic [5:0] progIndex;
    integer seed = 84666;
    int storeIdx = 0;
    int errors = 0;
    int checks = 0;
    int cycles = 0;

    processor dut_i (
        .clk, .rst, .startProcess, .endProcess, .instructionIF, .pcIF,
        .dMOutMem, .dMReadyMem, .memReadMem, .memWriteMem, .aluOutMem, .rs2DataMem
    );

    always #2 clk = ~clk;

    // Instruction memory answers in the same cycle
    assign progIndex = pcIF[7:2];
    assign instructionIF = (pcIF[31:8] == 24'd0 && progIndex < 6'(ProgLen)) ?
                           Program[progIndex] : coreDefs::NopInstr;

    task automatic checkStore(input logic [31:0] addr, input logic [31:0] data);
        checks += 2;
        assert (data != Marker) else begin
            errors++;
            $display("A store of the marker value reached memory at address %h", addr);
        end
        assert (storeIdx < StoreCount) else begin
            errors++;
            $display("Unexpected extra store of %h to address %h", data, addr);
        end
        if (storeIdx < StoreCount) begin
            checks += 2;
            assert (addr == StoreAddr[storeIdx]) else begin
                errors++;
                $display("[FAIL] %s address expected %h actual %h",
                         storeName[storeIdx], StoreAddr[storeIdx], addr);
            end
            assert (data == StoreData[storeIdx]) else begin
                errors++;
                $display("[FAIL] %s data expected %h actual %h",
                         storeName[storeIdx], StoreData[storeIdx], data);
            end
        end
        storeIdx++;
        dataMem[addr[7:2]] = data;
    endtask

    // Data memory with a random ready delay per request
    always @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < 64; k++) begin
                dataMem[k] = 32'hA500_0000 | (k * 4);
            end
            dMReadyMem <= 1'b0;
            busy = 1'b0;
        end else if (memReadMem || memWriteMem) begin
            if (dMReadyMem) begin
                checks++;
                assert (aluOutMem == heldAddr) else begin
                    errors++;
                    $display("[FAIL] addr_hold expected %h actual %h", heldAddr, aluOutMem);
                end
                if (memWriteMem) begin
                    checks++;
                    assert (rs2DataMem == heldData) else begin
                        errors++;
                        $display("[FAIL] data_hold expected %h actual %h",
                                 heldData, rs2DataMem);
                    end
                    checkStore(aluOutMem, rs2DataMem);
                end
                dMReadyMem <= 1'b0;
                busy = 1'b0;
            end else begin
                if (!busy) begin
                    busy = 1'b1;
                    heldAddr = aluOutMem;
                    heldData = rs2DataMem;
                    rnd = $random(seed);
                    waitLeft = rnd[1:0];
                end
                if (waitLeft == 2'd0) begin
                    dMReadyMem <= 1'b1;
                    dMOutMem <= dataMem[aluOutMem[7:2]];
                end else begin
                    waitLeft = waitLeft - 2'd1;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > TimeoutCycles) begin
            errors++;
            $display("Timeout after %0d cycles, the halt was never reached", TimeoutCycles);
            $display("Checks: %0d, errors: %0d", checks, errors);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        rst = 1'b1;
        startProcess = 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        // Idle until started
        repeat (4) begin
            @(negedge clk);
            checks++;
            assert (pcIF == 32'd0 && !memReadMem && !memWriteMem && !endProcess) else begin
                errors++;
                $display("Core not idle after reset, pcIF %h memRead %b memWrite %b end %b",
                         pcIF, memReadMem, memWriteMem, endProcess);
            end
        end

        @(posedge clk);
        startProcess <= 1'b1;
        @(posedge clk);
        startProcess <= 1'b0;

        while (!endProcess) @(negedge clk);
        checks++;
        assert (storeIdx == StoreCount) else begin
            errors++;
            $display("[FAIL] stores_at_halt expected %0d actual %0d", StoreCount, storeIdx);
        end

        // Nothing may be stored after the halt
        repeat (20) @(negedge clk);
        checks += 2;
        assert (storeIdx == StoreCount) else begin
            errors++;
            $display("[FAIL] stores_after_halt expected %0d actual %0d", StoreCount, storeIdx);
        end
        assert (endProcess) else begin
            errors++;
            $display("endProcess dropped without a new start");
        end

        for (int k = 0; k < StoreCount; k++) begin
            checks++;
            assert (dataMem[StoreAddr[k][7:2]] == StoreData[k]) else begin
                errors++;
                $display("[FAIL] %s memory expected %h actual %h",
                         storeName[k], StoreData[k], dataMem[StoreAddr[k][7:2]]);
            end
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end
endmodule

`default_nettype wire

//--- tests/processor_props.sv
`default_nettype none

module processorProps (
    input logic clk,
    input logic rst,
    input logic memReadMem,
    input logic memWriteMem,
    input logic dMReadyMem,
    input logic endProcess,
    input logic [31:0] aluOutMem,
    input logic [31:0] rs2DataMem
);
    timeunit 1ns;
    timeprecision 100ps;

    noBothValid: assert property (@(posedge clk) disable iff (rst)
        !(memReadMem && memWriteMem))
        else $error("memRead and memWrite are high in the same cycle");

    // Pending request keeps its address until ready
    addrHeld: assert property (@(posedge clk) disable iff (rst)
        ((memReadMem || memWriteMem) && !dMReadyMem)
        |=> ((memReadMem || memWriteMem) && $stable(aluOutMem)))
        else $error("Data port address or valid changed while waiting for ready");

    writeHeld: assert property (@(posedge clk) disable iff (rst)
        (memWriteMem && !dMReadyMem) |=> (memWriteMem && $stable(rs2DataMem)))
        else $error("Store data changed while waiting for ready");

    endLowAfterReset: assert property (@(posedge clk) rst |=> !endProcess)
        else $error("endProcess is high in the cycle after reset");
endmodule

bind processor processorProps props_i (
    .clk, .rst, .memReadMem, .memWriteMem, .dMReadyMem, .endProcess,
    .aluOutMem, .rs2DataMem
);

`default_nettype wire

//--- hw/processor.sv
`default_nettype none

module processor (
    input  logic clk,
    input  logic rst,
    input  logic startProcess,
    output logic endProcess,
    input  logic [31:0] instructionIF,
    output logic [31:0] pcIF,
    input  logic [31:0] dMOutMem,
    input  logic dMReadyMem,
    output logic memReadMem,
    output logic memWriteMem,
    output logic [31:0] aluOutMem,
    output logic [31:0] rs2DataMem
);
    logic [coreDefs::DataWidth-1:0] pcId, target, wbData;
    coreDefs::instr_t instrId;
    logic [coreDefs::RegAddrWidth-1:0] rs1Id, rs2Id, wbRd;
    logic [1:0] fwdA, fwdB;
    logic stall, redirect, haltSeen, memWait, wbRegWrite;

    idExBus idEx ();
    exMemBus exMem ();

    fetchStage fetch_i (
        .clk, .rst, .startProcess, .endProcess, .instructionIF,
        .stall, .memWait, .redirect, .target, .haltSeen,
        .pcIF, .pcId, .instrId
    );

    decodeStage decode_i (
        .clk, .rst, .instrId, .pcId, .stall, .memWait,
        .flush(redirect || haltSeen),
        .wbRegWrite, .wbRd, .wbData,
        .rs1Id, .rs2Id, .idEx(idEx.driver)
    );

    executeStage execute_i (
        .clk, .rst, .idEx(idEx.receiver), .fwdA, .fwdB, .memWait, .wbData,
        .redirect, .target, .haltSeen, .exMem(exMem.driver)
    );

    memoryStage memory_i (
        .clk, .rst, .startProcess, .exMem(exMem.receiver), .dMOutMem, .dMReadyMem,
        .memReadMem, .memWriteMem, .aluOutMem, .rs2DataMem, .memWait,
        .wbRegWrite, .wbRd, .wbData, .endProcess
    );

    hazardUnit hazard_i (
        .rs1Id, .rs2Id, .idEx(idEx.monitor), .exMem(exMem.monitor),
        .wbRegWrite, .wbRd, .fwdA, .fwdB, .stall
    );
endmodule

`default_nettype wire

//--- hw/hazardUnit.sv
`default_nettype none

module hazardUnit (
    input  logic [coreDefs::RegAddrWidth-1:0] rs1Id,
    input  logic [coreDefs::RegAddrWidth-1:0] rs2Id,
    idExBus.monitor idEx,
    exMemBus.monitor exMem,
    input  logic wbRegWrite,
    input  logic [coreDefs::RegAddrWidth-1:0] wbRd,
    output logic [1:0] fwdA,
    output logic [1:0] fwdB,
    output logic stall
);
    // Youngest producer wins
    function automatic logic [1:0] forwardFor(input logic [coreDefs::RegAddrWidth-1:0] src);
        if (src == '0) begin
            return coreDefs::FwdNone;
        end
        if (exMem.regWrite && exMem.rd == src) begin
            return coreDefs::FwdMem;
        end
        if (wbRegWrite && wbRd == src) begin
            return coreDefs::FwdWb;
        end
        return coreDefs::FwdNone;
    endfunction

    always_comb fwdA = forwardFor(idEx.rs1);
    always_comb fwdB = forwardFor(idEx.rs2);

    // Load in execute feeding the instruction in decode
    assign stall = idEx.memRead && idEx.rd != '0 && (idEx.rd == rs1Id || idEx.rd == rs2Id);
endmodule

`default_nettype wire

//--- hw/memoryStage.sv
`default_nettype none

module memoryStage (
    input  logic clk,
    input  logic rst,
    input  logic startProcess,
    exMemBus.receiver exMem,
    input  logic [coreDefs::DataWidth-1:0] dMOutMem,
    input  logic dMReadyMem,
    output logic memReadMem,
    output logic memWriteMem,
    output logic [coreDefs::DataWidth-1:0] aluOutMem,
    output logic [coreDefs::DataWidth-1:0] rs2DataMem,
    output logic memWait,
    output logic wbRegWrite,
    output logic [coreDefs::RegAddrWidth-1:0] wbRd,
    output logic [coreDefs::DataWidth-1:0] wbData,
    output logic endProcess
);
    // EX/MEM is frozen while waiting, so address and data hold
    assign memReadMem = exMem.memRead;
    assign memWriteMem = exMem.memWrite;
    assign aluOutMem = exMem.aluOut;
    assign rs2DataMem = exMem.storeData;
    assign memWait = (exMem.memRead || exMem.memWrite) && !dMReadyMem;

    always_ff @(posedge clk) begin
        if (rst) begin
            wbRegWrite <= 1'b0;
            endProcess <= 1'b0;
        end else begin
            if (!memWait) begin
                wbRegWrite <= exMem.regWrite;
                wbRd <= exMem.rd;
                // Load data taken in the handshake cycle
                wbData <= exMem.memToReg ? dMOutMem : exMem.aluOut;
            end
            if (startProcess) begin
                endProcess <= 1'b0;
            end else if (exMem.halt && !memWait) begin
                endProcess <= 1'b1;
            end
        end
    end
endmodule

`default_nettype wire

//--- hw/executeStage.sv
`default_nettype none

module executeStage (
    input  logic clk,
    input  logic rst,
    idExBus.receiver idEx,
    input  logic [1:0] fwdA,
    input  logic [1:0] fwdB,
    input  logic memWait,
    input  logic [coreDefs::DataWidth-1:0] wbData,
    output logic redirect,
    output logic [coreDefs::DataWidth-1:0] target,
    output logic haltSeen,
    exMemBus.driver exMem
);
    logic [coreDefs::DataWidth-1:0] opA, opB, aluA, aluB, aluResult;
    logic taken;

    function automatic logic [coreDefs::DataWidth-1:0] pickOperand(
        input logic [1:0] sel,
        input logic [coreDefs::DataWidth-1:0] regVal,
        input logic [coreDefs::DataWidth-1:0] memVal,
        input logic [coreDefs::DataWidth-1:0] wbVal
    );
        case (sel)
            coreDefs::FwdMem: return memVal;
            coreDefs::FwdWb: return wbVal;
            default: return regVal;
        endcase
    endfunction

    assign opA = pickOperand(fwdA, idEx.rs1Data, exMem.aluOut, wbData);
    assign opB = pickOperand(fwdB, idEx.rs2Data, exMem.aluOut, wbData);
    assign aluA = (idEx.srcA == coreDefs::SrcAPc) ? idEx.pc : opA;

    always_comb begin
        case (idEx.srcB)
            coreDefs::SrcBImm: aluB = idEx.imm;
            coreDefs::SrcBFour: aluB = 32'd4;
            default: aluB = opB;
        endcase
    end

    always_comb begin
        case (idEx.aluOp)
            coreDefs::AluSub: aluResult = aluA - aluB;
            coreDefs::AluAnd: aluResult = aluA & aluB;
            coreDefs::AluOr: aluResult = aluA | aluB;
            coreDefs::AluXor: aluResult = aluA ^ aluB;
            coreDefs::AluSlt: aluResult = {31'b0, $signed(aluA) < $signed(aluB)};
            coreDefs::AluPassB: aluResult = aluB;
            default: aluResult = aluA + aluB;
        endcase
    end

    // BEQ and BNE compare the forwarded register values
    assign taken = idEx.branch && ((opA == opB) ^ idEx.branchNe);
    assign redirect = taken || idEx.jump;
    assign target = idEx.pc + idEx.imm;
    assign haltSeen = idEx.halt;

    always_ff @(posedge clk) begin
        if (rst) begin
            {exMem.regWrite, exMem.memRead, exMem.memWrite, exMem.halt} <= '0;
        end else if (!memWait) begin
            exMem.aluOut <= aluResult;
            exMem.storeData <= opB;
            exMem.rd <= idEx.rd;
            exMem.memToReg <= idEx.memToReg;
            {exMem.regWrite, exMem.memRead, exMem.memWrite, exMem.halt} <=
                {idEx.regWrite, idEx.memRead, idEx.memWrite, idEx.halt};
        end
    end
endmodule

`default_nettype wire

//--- hw/decodeStage.sv
`default_nettype none

module decodeStage (
    input  logic clk,
    input  logic rst,
    input  coreDefs::instr_t instrId,
    input  logic [coreDefs::DataWidth-1:0] pcId,
    input  logic stall,
    input  logic memWait,
    input  logic flush,
    input  logic wbRegWrite,
    input  logic [coreDefs::RegAddrWidth-1:0] wbRd,
    input  logic [coreDefs::DataWidth-1:0] wbData,
    output logic [coreDefs::RegAddrWidth-1:0] rs1Id,
    output logic [coreDefs::RegAddrWidth-1:0] rs2Id,
    idExBus.driver idEx
);
    logic [coreDefs::DataWidth-1:0] rs1Data, rs2Data, imm;
    logic [2:0] aluOp;
    logic [1:0] srcA, srcB;
    logic regWrite, memRead, memWrite, memToReg, branch, jump, halt;

    assign rs1Id = instrId.r.rs1;
    assign rs2Id = instrId.r.rs2;

    regFile regs_i (
        .clk, .rst, .rs1(rs1Id), .rs2(rs2Id), .rd(wbRd), .wen(wbRegWrite),
        .writeData(wbData), .rs1Data, .rs2Data
    );

    always_comb begin
        imm = '0;
        aluOp = coreDefs::AluAdd;
        srcA = coreDefs::SrcAReg;
        srcB = coreDefs::SrcBImm;
        {regWrite, memRead, memWrite, memToReg, branch, jump, halt} = '0;
        case (instrId.r.opcode)
            coreDefs::OpReg: begin
                regWrite = 1'b1;
                srcB = coreDefs::SrcBReg;
                case (instrId.r.funct3)
                    3'b000: aluOp = instrId.r.funct7[5] ? coreDefs::AluSub : coreDefs::AluAdd;
                    3'b010: aluOp = coreDefs::AluSlt;
                    3'b100: aluOp = coreDefs::AluXor;
                    3'b110: aluOp = coreDefs::AluOr;
                    3'b111: aluOp = coreDefs::AluAnd;
                    default: aluOp = coreDefs::AluAdd;
                endcase
            end
            coreDefs::OpImm, coreDefs::OpLoad: begin
                imm = {{20{instrId.i.imm[11]}}, instrId.i.imm};
                regWrite = 1'b1;
                memRead = instrId.i.opcode == coreDefs::OpLoad;
                memToReg = memRead;
            end
            coreDefs::OpStore: begin
                imm = {{20{instrId.s.immHi[6]}}, instrId.s.immHi, instrId.s.immLo};
                memWrite = 1'b1;
            end
            coreDefs::OpLui: begin
                imm = {instrId.u.imm, 12'b0};
                aluOp = coreDefs::AluPassB;
                regWrite = 1'b1;
            end
            coreDefs::OpBranch: begin
                imm = {{19{instrId.b.imm12}}, instrId.b.imm12, instrId.b.imm11,
                       instrId.b.imm10to5, instrId.b.imm4to1, 1'b0};
                branch = 1'b1;
            end
            coreDefs::OpJal: begin
                imm = {{11{instrId.j.imm20}}, instrId.j.imm20, instrId.j.imm19to12,
                       instrId.j.imm11, instrId.j.imm10to1, 1'b0};
                // Link value pc + 4 comes out of the ALU
                srcA = coreDefs::SrcAPc;
                srcB = coreDefs::SrcBFour;
                regWrite = 1'b1;
                jump = 1'b1;
            end
            coreDefs::OpSystem: halt = 1'b1;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            {idEx.regWrite, idEx.memRead, idEx.memWrite, idEx.memToReg} <= '0;
            {idEx.branch, idEx.jump, idEx.halt} <= '0;
        end else if (!memWait) begin
            idEx.pc <= pcId;
            idEx.rs1Data <= rs1Data;
            idEx.rs2Data <= rs2Data;
            idEx.rs1 <= rs1Id;
            idEx.rs2 <= rs2Id;
            idEx.rd <= instrId.r.rd;
            idEx.imm <= imm;
            idEx.aluOp <= aluOp;
            idEx.srcA <= srcA;
            idEx.srcB <= srcB;
            idEx.branchNe <= instrId.b.funct3[0];
            if (stall || flush) begin
                {idEx.regWrite, idEx.memRead, idEx.memWrite, idEx.memToReg} <= '0;
                {idEx.branch, idEx.jump, idEx.halt} <= '0;
            end else begin
                {idEx.regWrite, idEx.memRead, idEx.memWrite, idEx.memToReg} <=
                    {regWrite, memRead, memWrite, memToReg};
                {idEx.branch, idEx.jump, idEx.halt} <= {branch, jump, halt};
            end
        end
    end
endmodule

`default_nettype wire

//--- hw/fetchStage.sv
`default_nettype none

module fetchStage (
    input  logic clk,
    input  logic rst,
    input  logic startProcess,
    input  logic endProcess,
    input  logic [coreDefs::DataWidth-1:0] instructionIF,
    input  logic stall,
    input  logic memWait,
    input  logic redirect,
    input  logic [coreDefs::DataWidth-1:0] target,
    input  logic haltSeen,
    output logic [coreDefs::DataWidth-1:0] pcIF,
    output logic [coreDefs::DataWidth-1:0] pcId,
    output coreDefs::instr_t instrId
);
    logic running;

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            pcIF <= '0;
            instrId <= coreDefs::NopInstr;
        end else begin
            if (haltSeen) begin
                running <= 1'b0;
            end else if (startProcess) begin
                running <= 1'b1;
            end

            // A new start after a finished run fetches from zero again
            if (startProcess && endProcess) begin
                pcIF <= '0;
            end else if (running && !memWait) begin
                if (redirect) begin
                    pcIF <= target;
                end else if (!stall) begin
                    pcIF <= pcIF + 32'd4;
                end
            end

            if (!memWait) begin
                if (redirect || haltSeen) begin
                    instrId <= coreDefs::NopInstr;
                end else if (running && !stall) begin
                    instrId <= instructionIF;
                    pcId <= pcIF;
                end
            end
        end
    end
endmodule

`default_nettype wire

//--- hw/regFile.sv
`default_nettype none

module regFile (
    input  logic clk,
    input  logic rst,
    input  logic [coreDefs::RegAddrWidth-1:0] rs1,
    input  logic [coreDefs::RegAddrWidth-1:0] rs2,
    input  logic [coreDefs::RegAddrWidth-1:0] rd,
    input  logic wen,
    input  logic [coreDefs::DataWidth-1:0] writeData,
    output logic [coreDefs::DataWidth-1:0] rs1Data,
    output logic [coreDefs::DataWidth-1:0] rs2Data
);
    logic [coreDefs::DataWidth-1:0] regs [coreDefs::RegCount];

    // Same-cycle write is seen by the read
    function automatic logic [coreDefs::DataWidth-1:0] readReg(
        input logic [coreDefs::RegAddrWidth-1:0] addr
    );
        if (addr == '0) begin
            return '0;
        end
        if (wen && addr == rd) begin
            return writeData;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < coreDefs::RegCount; k++) begin
                regs[k] <= '0;
            end
        end else if (wen && rd != '0) begin
            regs[rd] <= writeData;
        end
    end

    always_comb rs1Data = readReg(rs1);
    always_comb rs2Data = readReg(rs2);
endmodule

`default_nettype wire

//--- hw/pipeBus.sv
`default_nettype none

interface idExBus;
    logic [coreDefs::DataWidth-1:0] pc;
    logic [coreDefs::DataWidth-1:0] rs1Data;
    logic [coreDefs::DataWidth-1:0] rs2Data;
    logic [coreDefs::RegAddrWidth-1:0] rs1;
    logic [coreDefs::RegAddrWidth-1:0] rs2;
    logic [coreDefs::RegAddrWidth-1:0] rd;
    logic [coreDefs::DataWidth-1:0] imm;
    logic [2:0] aluOp;
    logic [1:0] srcA;
    logic [1:0] srcB;
    logic regWrite, memRead, memWrite, memToReg;
    logic branch, branchNe, jump, halt;

    modport driver(
        output pc, rs1Data, rs2Data, rs1, rs2, rd, imm, aluOp, srcA, srcB,
        output regWrite, memRead, memWrite, memToReg, branch, branchNe, jump, halt
    );
    modport receiver(
        input pc, rs1Data, rs2Data, rs1, rs2, rd, imm, aluOp, srcA, srcB,
        input regWrite, memRead, memWrite, memToReg, branch, branchNe, jump, halt
    );
    // Hazard checks need the sources too for forwarding
    modport monitor(input rs1, rs2, rd, memRead);
endinterface

interface exMemBus;
    logic [coreDefs::DataWidth-1:0] aluOut;
    logic [coreDefs::DataWidth-1:0] storeData;
    logic [coreDefs::RegAddrWidth-1:0] rd;
    logic regWrite, memRead, memWrite, memToReg, halt;

    modport driver(output aluOut, storeData, rd, regWrite, memRead, memWrite, memToReg, halt);
    modport receiver(input aluOut, storeData, rd, regWrite, memRead, memWrite, memToReg, halt);
    modport monitor(input rd, regWrite);
endinterface

`default_nettype wire

//--- hw/coreDefs.sv
`default_nettype none

package coreDefs;
    localparam int DataWidth = 32;
    localparam int RegCount = 32;
    localparam int RegAddrWidth = 5;

    localparam logic [6:0] OpReg = 7'b0110011;
    localparam logic [6:0] OpImm = 7'b0010011;
    localparam logic [6:0] OpLui = 7'b0110111;
    localparam logic [6:0] OpLoad = 7'b0000011;
    localparam logic [6:0] OpStore = 7'b0100011;
    localparam logic [6:0] OpBranch = 7'b1100011;
    localparam logic [6:0] OpJal = 7'b1101111;
    localparam logic [6:0] OpSystem = 7'b1110011;

    localparam logic [2:0] AluAdd = 3'd0;
    localparam logic [2:0] AluSub = 3'd1;
    localparam logic [2:0] AluAnd = 3'd2;
    localparam logic [2:0] AluOr = 3'd3;
    localparam logic [2:0] AluXor = 3'd4;
    localparam logic [2:0] AluSlt = 3'd5;
    localparam logic [2:0] AluPassB = 3'd6;

    localparam logic [1:0] SrcAReg = 2'd0;
    localparam logic [1:0] SrcAPc = 2'd1;
    localparam logic [1:0] SrcBReg = 2'd0;
    localparam logic [1:0] SrcBImm = 2'd1;
    localparam logic [1:0] SrcBFour = 2'd2;

    localparam logic [1:0] FwdNone = 2'd0;
    localparam logic [1:0] FwdMem = 2'd1;
    localparam logic [1:0] FwdWb = 2'd2;

    // One instruction word in six format views
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [RegAddrWidth-1:0] rs2;
            logic [RegAddrWidth-1:0] rs1;
            logic [2:0] funct3;
            logic [RegAddrWidth-1:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [RegAddrWidth-1:0] rs1;
            logic [2:0] funct3;
            logic [RegAddrWidth-1:0] rd;
            logic [6:0] opcode;
        } i;
        struct packed {
            logic [6:0] immHi;
            logic [RegAddrWidth-1:0] rs2;
            logic [RegAddrWidth-1:0] rs1;
            logic [2:0] funct3;
            logic [4:0] immLo;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic imm12;
            logic [5:0] imm10to5;
            logic [RegAddrWidth-1:0] rs2;
            logic [RegAddrWidth-1:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4to1;
            logic imm11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] imm;
            logic [RegAddrWidth-1:0] rd;
            logic [6:0] opcode;
        } u;
        struct packed {
            logic imm20;
            logic [9:0] imm10to1;
            logic imm11;
            logic [7:0] imm19to12;
            logic [RegAddrWidth-1:0] rd;
            logic [6:0] opcode;
        } j;
    } instr_t;

    // addi x0, x0, 0
    localparam logic [DataWidth-1:0] NopInstr = 32'h0000_0013;
endpackage

`default_nettype wire
